/* issuePkg.sv */
package issuePkg;

	////////////////////////////////////////////////////////////
	// Datapath types
	////////////////////////////////////////////////////////////

	// One RV32 data word
	typedef logic [31:0] wordT;

	// x0..x31
	typedef logic [4:0] regAddrT;

	////////////////////////////////////////////////////////////
	// Control fields carried from decode to execute
	////////////////////////////////////////////////////////////

	// ALU function passed through to execute
	typedef logic [3:0] aluFnT;

	// Zero code, so a bubble executes as an add
	localparam aluFnT aluAdd = 4'd0;

	// Operand B source
	typedef enum logic [1:0]
	{
		bSelReg = 2'd0,
		bSelImm = 2'd1,
		bSelShamt = 2'd2
	} bSelT;

	// Memory operation
	typedef logic [3:0] memOpT;
	localparam memOpT memNone = 4'd0;
	localparam memOpT memLoad = 4'd1;
	localparam memOpT memStore = 4'd2;

	// Instructions killed behind a taken branch or jump
	localparam int squashCycles = 2;

endpackage

/* regFile.sv */
`timescale 1ns/1ps

module regFile
(
	input logic clk,
	input logic nrst,
	input logic we,
	input issuePkg::regAddrT writeAddr,
	input issuePkg::regAddrT readAddrA,
	input issuePkg::regAddrT readAddrB,
	input issuePkg::wordT writeData,
	output issuePkg::wordT readDataA,
	output issuePkg::wordT readDataB
);
	import issuePkg::*;

	// Storage for x1..x31 only
	wordT regArray [1:31];

	// One read port with x0 and write-through bypass
	function automatic wordT readPort(regAddrT addr);
		wordT value;
		if (addr == '0)
		begin
			value = '0;
		end
		else if (we && (writeAddr == addr))
		begin
			value = writeData;
		end
		else
		begin
			value = regArray[addr];
		end
		return value;
	endfunction

	// Writeback port drops writes to x0
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 1; i <= 31; i++)
			begin
				regArray[i] <= '0;
			end
		end
		else if (we && (writeAddr != '0))
		begin
			regArray[writeAddr] <= writeData;
		end
	end

	always_comb
	begin
		readDataA = readPort(readAddrA);
		readDataB = readPort(readAddrB);
	end

endmodule

/* hazardScoreboard.sv */
`timescale 1ns/1ps

module hazardScoreboard
(
	input logic clk,
	input logic nrst,
	input issuePkg::regAddrT rs1,
	input issuePkg::regAddrT rs2,
	input issuePkg::regAddrT issueRd,
	input logic issueWe,
	input issuePkg::memOpT issueMemOp,
	input logic bjTaken,
	output logic hazard,
	output logic squash
);
	import issuePkg::*;

	// Wide enough for squashCycles - 1
	localparam int countWidth = $clog2(squashCycles + 1);

	logic loadInIssue;
	logic rs1Match;
	logic rs2Match;
	logic [countWidth-1:0] squashCount;

	////////////////////////////////////////////////////////////
	// Load-use detection
	////////////////////////////////////////////////////////////

	// A load that really writes a register sits in issue
	assign loadInIssue = issueWe && (issueMemOp == memLoad) && (issueRd != '0);

	// Decode sources against the load target
	assign rs1Match = (rs1 == issueRd);
	assign rs2Match = (rs2 == issueRd);

	// Data comes back one cycle too late for the dependent instruction,
	// so one bubble is enough
	assign hazard = loadInIssue && (rs1Match || rs2Match);

	////////////////////////////////////////////////////////////
	// Squash after a taken branch or jump
	////////////////////////////////////////////////////////////

	// The pulse itself kills the first instruction, the counter the rest
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			squashCount <= '0;
		end
		else if (bjTaken)
		begin
			squashCount <= countWidth'(squashCycles - 1);
		end
		else if (squashCount != '0)
		begin
			squashCount <= squashCount - 1'b1;
		end
	end

	// Pulse and remaining count give squashCycles bubbles in a row
	assign squash = bjTaken || (squashCount != '0);

endmodule

/* issueStage.sv */
`timescale 1ns/1ps

module issueStage
(
	input logic clk,
	input logic nrst,

	// From decode
	input issuePkg::regAddrT rs1,
	input issuePkg::regAddrT rs2,
	input issuePkg::regAddrT rd,
	input logic we,
	input issuePkg::aluFnT aluFn,
	input issuePkg::bSelT bSel,
	input issuePkg::wordT imm,
	input logic [4:0] shamt,
	input issuePkg::memOpT memOp,
	input issuePkg::wordT pc,

	// From commit
	input logic wbWe,
	input issuePkg::regAddrT wbAddr,
	input issuePkg::wordT wbData,

	// From execute and the memory arbiter
	input logic bjTaken,
	input logic memBusy,

	// To execute
	output issuePkg::wordT opA,
	output issuePkg::wordT opB,
	output issuePkg::regAddrT rdEx,
	output logic weEx,
	output issuePkg::aluFnT aluFnEx,
	output issuePkg::memOpT memOpEx,
	output issuePkg::wordT pcEx,

	// To decode
	output logic stall
);
	import issuePkg::*;

	// Everything held in the issue pipe register
	typedef struct packed
	{
		wordT valA;
		wordT valB;
		wordT imm;
		logic [4:0] shamt;
		bSelT bSel;
		regAddrT rd;
		logic we;
		aluFnT aluFn;
		memOpT memOp;
		wordT pc;
	} pipeT;

	// No write, no memory access, add of zeros
	localparam pipeT bubbleInstr = '{
		valA: '0,
		valB: '0,
		imm: '0,
		shamt: '0,
		bSel: bSelImm,
		rd: '0,
		we: 1'b0,
		aluFn: aluAdd,
		memOp: memNone,
		pc: '0
	};

	wordT readDataA;
	wordT readDataB;
	logic hazard;
	logic squash;
	pipeT decodeInstr;
	pipeT pipeNext;
	pipeT pipeReg;

	////////////////////////////////////////////////////////////
	// Register file and scoreboard
	////////////////////////////////////////////////////////////

	regFile regs
	(
		.clk(clk),
		.nrst(nrst),
		.we(wbWe),
		.writeAddr(wbAddr),
		.readAddrA(rs1),
		.readAddrB(rs2),
		.writeData(wbData),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	// Looks at the instruction now in issue, not at the next one
	hazardScoreboard scoreboard
	(
		.clk(clk),
		.nrst(nrst),
		.rs1(rs1),
		.rs2(rs2),
		.issueRd(pipeReg.rd),
		.issueWe(pipeReg.we),
		.issueMemOp(pipeReg.memOp),
		.bjTaken(bjTaken),
		.hazard(hazard),
		.squash(squash)
	);

	////////////////////////////////////////////////////////////
	// Issue pipe register
	////////////////////////////////////////////////////////////

	// Instruction offered by decode with its operands
	always_comb
	begin
		decodeInstr.valA = readDataA;
		decodeInstr.valB = readDataB;
		decodeInstr.imm = imm;
		decodeInstr.shamt = shamt;
		decodeInstr.bSel = bSel;
		decodeInstr.rd = rd;
		decodeInstr.we = we;
		decodeInstr.aluFn = aluFn;
		decodeInstr.memOp = memOp;
		decodeInstr.pc = pc;
	end

	// Squash beats the memory hold, the hold beats the load-use bubble
	always_comb
	begin
		if (squash)
		begin
			pipeNext = bubbleInstr;
		end
		else if (memBusy)
		begin
			pipeNext = pipeReg;
		end
		else if (hazard)
		begin
			pipeNext = bubbleInstr;
		end
		else
		begin
			pipeNext = decodeInstr;
		end
	end

	// Comes out of reset holding a bubble
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pipeReg <= bubbleInstr;
		end
		else
		begin
			pipeReg <= pipeNext;
		end
	end

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////

	// Operand B from register, I immediate or shift amount
	always_comb
	begin
		case (pipeReg.bSel)
			bSelReg: opB = pipeReg.valB;
			bSelImm: opB = pipeReg.imm;
			bSelShamt: opB = {27'd0, pipeReg.shamt};
			default: opB = pipeReg.valB;
		endcase
	end

	assign opA = pipeReg.valA;
	assign rdEx = pipeReg.rd;
	assign weEx = pipeReg.we;
	assign aluFnEx = pipeReg.aluFn;
	assign memOpEx = pipeReg.memOp;
	assign pcEx = pipeReg.pc;

	// Decode holds its instruction on either cause
	assign stall = hazard || memBusy;

endmodule

/* issueStage_sva.sv */
`timescale 1ns/1ps

module issueStageSva
(
	input logic clk,
	input logic nrst,
	input logic bjTaken,
	input logic memBusy,
	input logic squash,
	input logic stall,
	input logic weEx,
	input issuePkg::memOpT memOpEx,
	input issuePkg::aluFnT aluFnEx,
	input issuePkg::wordT opA,
	input issuePkg::wordT opB,
	input issuePkg::regAddrT rdEx,
	input issuePkg::wordT pcEx
);
	import issuePkg::*;

	// Two bubbles behind a taken branch
	branchBubbles: assert property (@(posedge clk) disable iff (!nrst)
		bjTaken |=> (!weEx && memOpEx == memNone) ##1 (!weEx && memOpEx == memNone))
		else $error("execute outputs not a bubble after a taken branch");

	// Memory hold freezes the execute outputs
	holdStable: assert property (@(posedge clk) disable iff (!nrst)
		(memBusy && !squash) |=> ($stable(opA) && $stable(opB) && $stable(rdEx)
			&& $stable(weEx) && $stable(aluFnEx) && $stable(memOpEx) && $stable(pcEx)))
		else $error("execute outputs changed during memory hold");

	// First edge out of reset
	resetStall: assert property (@(posedge clk)
		(!$past(nrst) && nrst && !memBusy) |-> !stall)
		else $error("stall high right after reset");

endmodule

bind issueStage issueStageSva sva
(
	.clk(clk),
	.nrst(nrst),
	.bjTaken(bjTaken),
	.memBusy(memBusy),
	.squash(squash),
	.stall(stall),
	.weEx(weEx),
	.memOpEx(memOpEx),
	.aluFnEx(aluFnEx),
	.opA(opA),
	.opB(opB),
	.rdEx(rdEx),
	.pcEx(pcEx)
);

/* issueStageTb.sv */
`timescale 1ns/1ps

module issueStageTb;
	import issuePkg::*;

	typedef struct packed
	{
		regAddrT rs1;
		regAddrT rs2;
		regAddrT rd;
		logic we;
		aluFnT aluFn;
		bSelT bSel;
		wordT imm;
		logic [4:0] shamt;
		memOpT memOp;
		wordT pc;
		logic wbWe;
		regAddrT wbAddr;
		logic bj;
		logic [3:0] busy;
	} rowT;

	typedef struct packed
	{
		wordT opA;
		wordT opB;
		regAddrT rd;
		logic we;
		aluFnT aluFn;
		memOpT memOp;
		wordT pc;
	} expT;

	localparam expT bubbleExp = '0;

	logic clk = 0, nrst, we, wbWe, bjTaken, memBusy, weEx, stall;
	regAddrT rs1, rs2, rd, wbAddr, rdEx;
	aluFnT aluFn, aluFnEx;
	bSelT bSel;
	wordT imm, pc, wbData, opA, opB, pcEx;
	logic [4:0] shamt;
	memOpT memOp, memOpEx;

	rowT rows[$];
	expT expQ[$];
	expT model;
	wordT refRegs [0:31];
	int squashLeft;
	int cycles = 0;
	int cycleLimit = 0;
	logic [31:0] lfsr = 32'hda78_0083;

	issueStage dut (.*);

	always #5 clk = ~clk;

	// Ends a run that never reaches its last row
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles > cycleLimit)
		begin
			$display("Timeout: the stimulus table did not finish in %0d cycles", cycleLimit);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic drawWord(output wordT w);
		for (int i = 0; i < 32; i++)
		begin
			lfsr = lfsrNext(lfsr);
			w[i] = lfsr[0];
		end
	endtask

	task automatic addRow(regAddrT s1, regAddrT s2, regAddrT d, logic w, aluFnT fn, bSelT bs,
		wordT im, logic [4:0] sh, memOpT mo, wordT p, logic wbw, regAddrT wba, logic b,
		logic [3:0] busy);
		rows.push_back('{s1, s2, d, w, fn, bs, im, sh, mo, p, wbw, wba, b, busy});
	endtask

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic fail(string msg);
		$display("error %0t: %s", $time, msg);
		$display("Test failed");
		$fatal(1, "mismatch");
	endtask

	task automatic checkWord(string name, wordT got, wordT exp);
		if (got !== exp)
			fail($sformatf("%s is %h, expected %h", name, got, exp));
	endtask

	task automatic checkAddr(string name, regAddrT got, regAddrT exp);
		if (got !== exp)
			fail($sformatf("%s is %0d, expected %0d", name, got, exp));
	endtask

	task automatic checkMemOp(string name, memOpT got, memOpT exp);
		if (got !== exp)
			fail($sformatf("%s is %h, expected %h", name, got, exp));
	endtask

	task automatic checkAluFn(string name, aluFnT got, aluFnT exp);
		if (got !== exp)
			fail($sformatf("%s is %h, expected %h", name, got, exp));
	endtask

	task automatic checkBit(string name, logic got, logic exp);
		if (got !== exp)
			fail($sformatf("%s is %b, expected %b", name, got, exp));
	endtask

	task automatic checkOutputs(expT e);
		checkWord("opA", opA, e.opA);
		checkWord("opB", opB, e.opB);
		checkAddr("rdEx", rdEx, e.rd);
		checkBit("weEx", weEx, e.we);
		checkAluFn("aluFnEx", aluFnEx, e.aluFn);
		checkMemOp("memOpEx", memOpEx, e.memOp);
		checkWord("pcEx", pcEx, e.pc);
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Register read with x0 and same-cycle writeback
	function automatic wordT readRef(regAddrT a, logic wbw, regAddrT wba, wordT wbd);
		if (a == 0)
			return '0;
		if (wbw && wba == a)
			return wbd;
		return refRegs[a];
	endfunction

	task automatic stepModel(rowT r, logic first, logic busyNow, wordT wbd, output logic expStall);
		logic bjNow, wbNow, squashNow, hazardNow;
		expT next;
		wordT valB;
		bjNow = first && r.bj;
		wbNow = first && r.wbWe;
		squashNow = bjNow || (squashLeft != 0);
		hazardNow = model.we && model.memOp == memLoad && model.rd != 0
			&& (r.rs1 == model.rd || r.rs2 == model.rd);
		expStall = hazardNow || busyNow;
		if (squashNow || (!busyNow && hazardNow))
			next = bubbleExp;
		else if (busyNow)
			next = model;
		else
		begin
			valB = readRef(r.rs2, wbNow, r.wbAddr, wbd);
			next.opA = readRef(r.rs1, wbNow, r.wbAddr, wbd);
			next.opB = (r.bSel == bSelReg) ? valB
				: (r.bSel == bSelImm) ? r.imm : {27'd0, r.shamt};
			next = '{next.opA, next.opB, r.rd, r.we, r.aluFn, r.memOp, r.pc};
		end
		if (bjNow)
			squashLeft = squashCycles - 1;
		else if (squashLeft != 0)
			squashLeft--;
		if (wbNow && r.wbAddr != 0)
			refRegs[r.wbAddr] = wbd;
		model = next;
		expQ.push_back(next);
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial
	begin
		logic first, expStall;
		logic [3:0] busyLeft;
		wordT wbd;
		{rs1, rs2, rd, we, aluFn, imm, shamt, memOp, pc} = '0;
		bSel = bSelReg;
		{wbWe, wbAddr, wbData, bjTaken, memBusy} = '0;
		nrst = 0;
		model = bubbleExp;
		squashLeft = 0;
		for (int i = 0; i < 32; i++)
			refRegs[i] = '0;

		// Writes, x0, operand B select, bypass
		addRow(0, 0, 0, 0, 4'd4, bSelReg, 0, 0, memNone, 32'h00, 1, 1, 0, 0);
		addRow(0, 0, 0, 0, 0, bSelReg, 0, 0, memNone, 32'h04, 1, 2, 0, 0);
		addRow(1, 2, 3, 1, 4'd3, bSelReg, 0, 0, memNone, 32'h08, 1, 0, 0, 0);
		addRow(0, 2, 4, 1, 4'd1, bSelImm, 32'h123, 0, memNone, 32'h0c, 0, 0, 0, 0);
		addRow(1, 0, 5, 1, 4'd5, bSelShamt, 0, 5'd7, memNone, 32'h10, 0, 0, 0, 0);
		addRow(4, 4, 6, 1, 4'd2, bSelReg, 0, 0, memNone, 32'h14, 1, 4, 0, 0);
		// Load-use
		addRow(1, 0, 6, 1, 0, bSelImm, 32'h8, 0, memLoad, 32'h18, 0, 0, 0, 0);
		addRow(6, 2, 7, 1, 4'd3, bSelReg, 0, 0, memNone, 32'h1c, 1, 6, 0, 0);
		// Branch squash
		addRow(1, 2, 8, 1, 4'd1, bSelReg, 0, 0, memNone, 32'h20, 0, 0, 1, 0);
		addRow(2, 1, 9, 1, 4'd1, bSelReg, 0, 0, memNone, 32'h24, 0, 0, 0, 0);
		addRow(3, 1, 10, 1, 4'd6, bSelReg, 0, 0, memNone, 32'h40, 0, 0, 0, 0);
		// Memory hold and a hold over a load-use
		addRow(4, 3, 11, 1, 4'd7, bSelReg, 0, 0, memNone, 32'h44, 0, 0, 0, 3);
		addRow(1, 6, 0, 0, 0, bSelImm, 32'h10, 0, memStore, 32'h48, 0, 0, 0, 0);
		addRow(2, 0, 12, 1, 0, bSelImm, 32'h4, 0, memLoad, 32'h4c, 0, 0, 0, 0);
		addRow(0, 12, 13, 1, 4'd2, bSelReg, 0, 0, memNone, 32'h50, 1, 12, 0, 2);
		addRow(0, 0, 0, 0, 0, bSelReg, 0, 0, memNone, 32'h54, 0, 0, 0, 0);
		cycleLimit = rows.size() * 4 + 20;

		repeat (8) @(posedge clk);
		#1 nrst = 1;
		#1 checkOutputs(bubbleExp);
		checkBit("stall", stall, 1'b0);

		foreach (rows[i])
		begin
			first = 1;
			busyLeft = rows[i].busy;
			expStall = 1;
			while (expStall)
			begin
				wbd = '0;
				if (first && rows[i].wbWe)
					drawWord(wbd);
				{rs1, rs2, rd, we, aluFn} = {rows[i].rs1, rows[i].rs2, rows[i].rd, rows[i].we,
					rows[i].aluFn};
				bSel = rows[i].bSel;
				{imm, shamt, memOp, pc} = {rows[i].imm, rows[i].shamt, rows[i].memOp,
					rows[i].pc};
				wbWe = first && rows[i].wbWe;
				wbAddr = rows[i].wbAddr;
				wbData = wbd;
				bjTaken = first && rows[i].bj;
				memBusy = (busyLeft != 0);
				stepModel(rows[i], first, memBusy, wbd, expStall);
				#1 checkBit("stall", stall, expStall);
				@(posedge clk);
				#1 checkOutputs(expQ.pop_front());
				first = 0;
				if (busyLeft != 0)
					busyLeft--;
			end
		end

		$display("Test passed");
		$finish;
	end

endmodule

/* verilog.f */
issuePkg.sv
regFile.sv
hazardScoreboard.sv
issueStage.sv
issueStage_sva.sv
issueStageTb.sv

/* run.sh */
#!/bin/bash
# Build and run the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f verilog.f --top-module issueStageTb -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -q "Test passed" \
	&& echo "Simulation PASSED" \
	|| { echo "Simulation FAILED"; exit 1; }
